// File: source/decoder_consts.svh
`ifndef DECODER_CONSTS_SVH
`define DECODER_CONSTS_SVH

// grid of one code patch, rounds stacked along u.
`define GRID_WIDTH_X 3
`define GRID_WIDTH_Z 2
`define GRID_WIDTH_U 3

`define MAX_WEIGHT 2

`define NEIGHBOR_COUNT 6
`define NEIGHBOR_NORTH 0
`define NEIGHBOR_SOUTH 1
`define NEIGHBOR_WEST 2
`define NEIGHBOR_EAST 3
`define NEIGHBOR_DOWN 4
`define NEIGHBOR_UP 5

`define PU_COUNT (`GRID_WIDTH_X * `GRID_WIDTH_Z * `GRID_WIDTH_U)

`define NS_EDGE_COUNT ((`GRID_WIDTH_X + 1) * `GRID_WIDTH_Z * `GRID_WIDTH_U)
`define EW_EDGE_COUNT (`GRID_WIDTH_X * (`GRID_WIDTH_Z + 1) * `GRID_WIDTH_U)
`define UD_EDGE_COUNT (`GRID_WIDTH_X * `GRID_WIDTH_Z * (`GRID_WIDTH_U + 1))
`define EDGE_COUNT (`NS_EDGE_COUNT + `EW_EDGE_COUNT + `UD_EDGE_COUNT)

`endif

// File: source/decoder_pkg.sv
`include "decoder_consts.svh"

package decoder_pkg;

    // coordinate field widths, at least one bit each.
    localparam int X_BITS = (`GRID_WIDTH_X > 1) ? $clog2(`GRID_WIDTH_X) : 1;
    localparam int Z_BITS = (`GRID_WIDTH_Z > 1) ? $clog2(`GRID_WIDTH_Z) : 1;
    localparam int U_BITS = (`GRID_WIDTH_U > 1) ? $clog2(`GRID_WIDTH_U) : 1;

    // round in the high bits, so the numeric value orders roots.
    typedef struct packed {
        logic [U_BITS-1:0] u;
        logic [X_BITS-1:0] x;
        logic [Z_BITS-1:0] z;
    } addr_t;

    typedef logic [$clog2(`MAX_WEIGHT + 1)-1:0] weight_t;

    // what a unit shows to each of its links.
    typedef struct packed {
        addr_t root;
        logic odd;
    } node_state_t;

    // what a link hands back to one of its sides.
    typedef struct packed {
        logic grown;
        logic boundary;
        addr_t peer_root;
    } link_view_t;

endpackage

// File: source/processing_unit.sv
`include "decoder_consts.svh"

module processing_unit #(
    parameter decoder_pkg::addr_t ADDRESS = '0
) (
    input  logic clk,
    input  logic rst_n,
    input  logic meas_valid,
    input  logic measurement,
    output logic measurement_out,
    input  decoder_pkg::link_view_t [`NEIGHBOR_COUNT-1:0] views,
    output decoder_pkg::addr_t root,
    output logic defect,
    output logic touches_boundary,
    output logic busy
);

    import decoder_pkg::*;

    logic meas_q;
    addr_t min_root;

    // defect is the raw measurement bit of this round.
    assign defect = meas_q;
    assign measurement_out = meas_q;

    // smallest root seen across fully grown links.
    always_comb begin
        min_root = root;
        touches_boundary = 1'b0;
        for (int n = 0; n < `NEIGHBOR_COUNT; n++) begin
            if (views[n].grown) begin
                if (views[n].boundary) begin
                    touches_boundary = 1'b1;
                end else if (views[n].peer_root < min_root) begin
                    min_root = views[n].peer_root;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            meas_q <= 1'b0;
            root <= ADDRESS;
            busy <= 1'b0;
        end else if (meas_valid) begin
            // new round shifts in and clusters start over.
            meas_q <= measurement;
            root <= ADDRESS;
            busy <= 1'b0;
        end else if (min_root < root) begin
            root <= min_root;
            busy <= 1'b1;
        end else begin
            busy <= 1'b0;
        end
    end

endmodule

// File: source/edge_link.sv
`include "decoder_consts.svh"

module edge_link #(
    parameter bit HAS_B_SIDE = 1'b1
) (
    input  logic clk,
    input  logic rst_n,
    input  logic meas_valid,
    input  logic grow_step,
    input  logic any_busy,
    input  decoder_pkg::node_state_t a_state,
    input  decoder_pkg::node_state_t b_state,
    output decoder_pkg::link_view_t a_view,
    output decoder_pkg::link_view_t b_view,
    output logic grown
);

    import decoder_pkg::*;

    weight_t weight;
    weight_t next_weight;
    logic b_odd;
    logic [$bits(weight_t):0] sum;
    addr_t a_peer;

    // a one-sided link only ever grows from its a side.
    assign b_odd = HAS_B_SIDE ? b_state.odd : 1'b0;
    assign a_peer = HAS_B_SIDE ? b_state.root : a_state.root;

    assign sum = weight + a_state.odd + b_odd;
    assign next_weight = (sum > `MAX_WEIGHT) ? weight_t'(`MAX_WEIGHT) : weight_t'(sum);

    assign grown = (weight == weight_t'(`MAX_WEIGHT));

    assign a_view = '{grown: grown, boundary: !HAS_B_SIDE, peer_root: a_peer};
    assign b_view = '{grown: grown, boundary: !HAS_B_SIDE, peer_root: a_state.root};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            weight <= '0;
        end else if (meas_valid) begin
            weight <= '0;
        end else if (grow_step && !any_busy) begin
            // growth waits until merging has settled.
            weight <= next_weight;
        end
    end

endmodule

// File: source/cluster_parity.sv
`include "decoder_consts.svh"

module cluster_parity (
    input  decoder_pkg::addr_t [`PU_COUNT-1:0] roots,
    input  logic [`PU_COUNT-1:0] defects,
    input  logic [`PU_COUNT-1:0] touches_boundary,
    input  logic [`PU_COUNT-1:0] busy,
    output logic [`PU_COUNT-1:0] odd,
    output logic any_busy
);

    logic parity;
    logic on_boundary;

    // every unit gathers its whole cluster by comparing roots.
    always_comb begin
        odd = '0;
        for (int p = 0; p < `PU_COUNT; p++) begin
            parity = 1'b0;
            on_boundary = 1'b0;
            for (int q = 0; q < `PU_COUNT; q++) begin
                if (roots[q] == roots[p]) begin
                    parity = parity ^ defects[q];
                    on_boundary = on_boundary | touches_boundary[q];
                end
            end
            // a cluster on a boundary can always be matched there.
            odd[p] = parity && !on_boundary;
        end
    end

    assign any_busy = |busy;

endmodule

// File: source/decoding_graph.sv
`include "decoder_consts.svh"

module decoding_graph (
    input  logic clk,
    input  logic rst_n,
    input  logic [`GRID_WIDTH_X*`GRID_WIDTH_Z-1:0] measurements,
    input  logic meas_valid,
    input  logic grow_step,
    output logic [`PU_COUNT-1:0] odd_clusters,
    output decoder_pkg::addr_t [`PU_COUNT-1:0] roots,
    output logic [`PU_COUNT-1:0] busy,
    output logic [`EDGE_COUNT-1:0] grown_edges
);

    import decoder_pkg::*;

    localparam int X = `GRID_WIDTH_X;
    localparam int Z = `GRID_WIDTH_Z;
    localparam int U = `GRID_WIDTH_U;
    localparam int EW_BASE = `NS_EDGE_COUNT;
    localparam int UD_BASE = `NS_EDGE_COUNT + `EW_EDGE_COUNT;

    link_view_t [`NEIGHBOR_COUNT-1:0] views [`PU_COUNT];
    node_state_t states [`PU_COUNT];
    logic [`PU_COUNT-1:0] meas_chain;
    logic [`PU_COUNT-1:0] defects;
    logic [`PU_COUNT-1:0] touches_boundary;
    logic any_busy;

    // unit index is round-major, then x, then z.
    for (genvar k = 0; k < U; k++) begin : g_u
        for (genvar i = 0; i < X; i++) begin : g_x
            for (genvar j = 0; j < Z; j++) begin : g_z
                localparam int P = k*X*Z + i*Z + j;
                localparam addr_t UNIT_ADDR = '{u: U_BITS'(k), x: X_BITS'(i), z: Z_BITS'(j)};

                logic meas_in;

                if (k == U-1) begin : g_top
                    assign meas_in = measurements[i*Z + j];
                end else begin : g_below
                    assign meas_in = meas_chain[P + X*Z];
                end

                processing_unit #(
                    .ADDRESS(UNIT_ADDR)
                ) u_pu (
                    .clk(clk),
                    .rst_n(rst_n),
                    .meas_valid(meas_valid),
                    .measurement(meas_in),
                    .measurement_out(meas_chain[P]),
                    .views(views[P]),
                    .root(roots[P]),
                    .defect(defects[P]),
                    .touches_boundary(touches_boundary[P]),
                    .busy(busy[P])
                );

                assign states[P] = '{root: roots[P], odd: odd_clusters[P]};
            end
        end
    end

    // north-south links, row i sits between x = i-1 and x = i.
    for (genvar k = 0; k < U; k++) begin : g_ns_u
        for (genvar i = 0; i <= X; i++) begin : g_ns_x
            for (genvar j = 0; j < Z; j++) begin : g_ns_z
                localparam int E = k*(X+1)*Z + i*Z + j;
                localparam int A_PU = k*X*Z + (i-1)*Z + j;
                localparam int B_PU = k*X*Z + i*Z + j;
                localparam int EDGE_PU = (i == 0) ? B_PU : A_PU;
                localparam int EDGE_DIR = (i == 0) ? `NEIGHBOR_NORTH : `NEIGHBOR_SOUTH;

                if (i == 0 || i == X) begin : g_boundary
                    edge_link #(.HAS_B_SIDE(1'b0)) u_link (
                        .clk(clk), .rst_n(rst_n),
                        .meas_valid(meas_valid), .grow_step(grow_step), .any_busy(any_busy),
                        .a_state(states[EDGE_PU]), .b_state(),
                        .a_view(views[EDGE_PU][EDGE_DIR]), .b_view(),
                        .grown(grown_edges[E])
                    );
                end else begin : g_inner
                    edge_link #(.HAS_B_SIDE(1'b1)) u_link (
                        .clk(clk), .rst_n(rst_n),
                        .meas_valid(meas_valid), .grow_step(grow_step), .any_busy(any_busy),
                        .a_state(states[A_PU]), .b_state(states[B_PU]),
                        .a_view(views[A_PU][`NEIGHBOR_SOUTH]),
                        .b_view(views[B_PU][`NEIGHBOR_NORTH]),
                        .grown(grown_edges[E])
                    );
                end
            end
        end
    end

    // east-west links along z.
    for (genvar k = 0; k < U; k++) begin : g_ew_u
        for (genvar i = 0; i < X; i++) begin : g_ew_x
            for (genvar j = 0; j <= Z; j++) begin : g_ew_z
                localparam int E = EW_BASE + k*X*(Z+1) + i*(Z+1) + j;
                localparam int A_PU = k*X*Z + i*Z + j - 1;
                localparam int B_PU = k*X*Z + i*Z + j;
                localparam int EDGE_PU = (j == 0) ? B_PU : A_PU;
                localparam int EDGE_DIR = (j == 0) ? `NEIGHBOR_WEST : `NEIGHBOR_EAST;

                if (j == 0 || j == Z) begin : g_boundary
                    edge_link #(.HAS_B_SIDE(1'b0)) u_link (
                        .clk(clk), .rst_n(rst_n),
                        .meas_valid(meas_valid), .grow_step(grow_step), .any_busy(any_busy),
                        .a_state(states[EDGE_PU]), .b_state(),
                        .a_view(views[EDGE_PU][EDGE_DIR]), .b_view(),
                        .grown(grown_edges[E])
                    );
                end else begin : g_inner
                    edge_link #(.HAS_B_SIDE(1'b1)) u_link (
                        .clk(clk), .rst_n(rst_n),
                        .meas_valid(meas_valid), .grow_step(grow_step), .any_busy(any_busy),
                        .a_state(states[A_PU]), .b_state(states[B_PU]),
                        .a_view(views[A_PU][`NEIGHBOR_EAST]),
                        .b_view(views[B_PU][`NEIGHBOR_WEST]),
                        .grown(grown_edges[E])
                    );
                end
            end
        end
    end

    // up-down links between rounds, with open ends below and above.
    for (genvar k = 0; k <= U; k++) begin : g_ud_u
        for (genvar i = 0; i < X; i++) begin : g_ud_x
            for (genvar j = 0; j < Z; j++) begin : g_ud_z
                localparam int E = UD_BASE + k*X*Z + i*Z + j;
                localparam int A_PU = (k-1)*X*Z + i*Z + j;
                localparam int B_PU = k*X*Z + i*Z + j;
                localparam int EDGE_PU = (k == 0) ? B_PU : A_PU;
                localparam int EDGE_DIR = (k == 0) ? `NEIGHBOR_DOWN : `NEIGHBOR_UP;

                if (k == 0 || k == U) begin : g_boundary
                    edge_link #(.HAS_B_SIDE(1'b0)) u_link (
                        .clk(clk), .rst_n(rst_n),
                        .meas_valid(meas_valid), .grow_step(grow_step), .any_busy(any_busy),
                        .a_state(states[EDGE_PU]), .b_state(),
                        .a_view(views[EDGE_PU][EDGE_DIR]), .b_view(),
                        .grown(grown_edges[E])
                    );
                end else begin : g_inner
                    edge_link #(.HAS_B_SIDE(1'b1)) u_link (
                        .clk(clk), .rst_n(rst_n),
                        .meas_valid(meas_valid), .grow_step(grow_step), .any_busy(any_busy),
                        .a_state(states[A_PU]), .b_state(states[B_PU]),
                        .a_view(views[A_PU][`NEIGHBOR_UP]),
                        .b_view(views[B_PU][`NEIGHBOR_DOWN]),
                        .grown(grown_edges[E])
                    );
                end
            end
        end
    end

    cluster_parity u_parity (
        .roots(roots),
        .defects(defects),
        .touches_boundary(touches_boundary),
        .busy(busy),
        .odd(odd_clusters),
        .any_busy(any_busy)
    );

endmodule

// File: bench/tb_decoding_graph.sv
`include "decoder_consts.svh"

module tb_decoding_graph;

    timeunit 1ns;
    timeprecision 1ps;

    import decoder_pkg::*;

    localparam int X = `GRID_WIDTH_X;
    localparam int Z = `GRID_WIDTH_Z;
    localparam int U = `GRID_WIDTH_U;
    localparam int PUS = `PU_COUNT;
    localparam int EDGES = `EDGE_COUNT;
    localparam int EPISODES = 20;
    localparam int MAX_STEPS = 8;
    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 8;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + EPISODES * (U + MAX_STEPS * 40);
    localparam int SETTLE_LIMIT = 4 * PUS;

    logic clk;
    logic rst_n;
    logic [X*Z-1:0] measurements;
    logic meas_valid;
    logic grow_step;
    logic [PUS-1:0] odd_clusters;
    addr_t [PUS-1:0] roots;
    logic [PUS-1:0] busy;
    logic [EDGES-1:0] grown_edges;

    // reference model state.
    int edge_a [EDGES];
    int edge_b [EDGES];
    int weights [EDGES];
    int parent [PUS];
    int model_root [PUS];
    logic [PUS-1:0] defects;
    logic [PUS-1:0] model_odd;
    logic [EDGES-1:0] model_grown;
    int error_count;
    int ignored_strobes;

    decoding_graph UUT (
        .clk(clk),
        .rst_n(rst_n),
        .measurements(measurements),
        .meas_valid(meas_valid),
        .grow_step(grow_step),
        .odd_clusters(odd_clusters),
        .roots(roots),
        .busy(busy),
        .grown_edges(grown_edges)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("Fail %s got 0x%0h expected 0x%0h", name, got, expected));
        end
    endtask

    function automatic int unit_index(int k, int i, int j);
        return k*X*Z + i*Z + j;
    endfunction

    // round in the high bits, then x, then z.
    function automatic int unit_address(int p);
        int k;
        int i;
        int j;
        k = p / (X*Z);
        i = (p % (X*Z)) / Z;
        j = p % Z;
        return (k << (X_BITS + Z_BITS)) | (i << Z_BITS) | j;
    endfunction

    function automatic int find_root(int p);
        int r;
        r = p;
        while (parent[r] != r) begin
            r = parent[r];
        end
        return r;
    endfunction

    // edge order is NS, EW, UD, each round-major, then x, then z.
    task automatic build_edges();
        int e;
        e = 0;
        for (int k = 0; k < U; k++)
            for (int i = 0; i <= X; i++)
                for (int j = 0; j < Z; j++) begin
                    edge_a[e] = (i == 0) ? unit_index(k, 0, j) : unit_index(k, i-1, j);
                    edge_b[e] = (i == 0 || i == X) ? -1 : unit_index(k, i, j);
                    e++;
                end
        for (int k = 0; k < U; k++)
            for (int i = 0; i < X; i++)
                for (int j = 0; j <= Z; j++) begin
                    edge_a[e] = (j == 0) ? unit_index(k, i, 0) : unit_index(k, i, j-1);
                    edge_b[e] = (j == 0 || j == Z) ? -1 : unit_index(k, i, j);
                    e++;
                end
        for (int k = 0; k <= U; k++)
            for (int i = 0; i < X; i++)
                for (int j = 0; j < Z; j++) begin
                    edge_a[e] = (k == 0) ? unit_index(0, i, j) : unit_index(k-1, i, j);
                    edge_b[e] = (k == 0 || k == U) ? -1 : unit_index(k, i, j);
                    e++;
                end
    endtask

    // union-find over grown inner links, then parity per cluster.
    task automatic update_model();
        int ra;
        int rb;
        int r;
        logic set_parity [PUS];
        logic set_boundary [PUS];
        for (int p = 0; p < PUS; p++) begin
            parent[p] = p;
            set_parity[p] = 1'b0;
            set_boundary[p] = 1'b0;
        end
        for (int e = 0; e < EDGES; e++) begin
            model_grown[e] = (weights[e] == `MAX_WEIGHT);
            if (model_grown[e] && edge_b[e] >= 0) begin
                ra = find_root(edge_a[e]);
                rb = find_root(edge_b[e]);
                if (ra != rb) begin
                    if (unit_address(ra) < unit_address(rb)) parent[rb] = ra;
                    else parent[ra] = rb;
                end
            end
        end
        for (int p = 0; p < PUS; p++) begin
            r = find_root(p);
            model_root[p] = unit_address(r);
            set_parity[r] = set_parity[r] ^ defects[p];
        end
        for (int e = 0; e < EDGES; e++) begin
            if (model_grown[e] && edge_b[e] < 0) set_boundary[find_root(edge_a[e])] = 1'b1;
        end
        for (int p = 0; p < PUS; p++) begin
            r = find_root(p);
            model_odd[p] = set_parity[r] && !set_boundary[r];
        end
    endtask

    task automatic apply_growth();
        int inc;
        for (int e = 0; e < EDGES; e++) begin
            inc = model_odd[edge_a[e]];
            if (edge_b[e] >= 0) inc += model_odd[edge_b[e]];
            weights[e] = (weights[e] + inc > `MAX_WEIGHT) ? `MAX_WEIGHT : weights[e] + inc;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic check_state();
        check_value("grown_edges", grown_edges, model_grown);
        for (int p = 0; p < PUS; p++) begin
            check_value($sformatf("roots[%0d]", p), roots[p], model_root[p]);
        end
        check_value("odd_clusters", odd_clusters, model_odd);
        check_value("busy", busy, '0);
    endtask

    // top layer takes the new round, the rest shift down.
    task automatic load_round(input logic [X*Z-1:0] m);
        measurements = m;
        meas_valid = 1'b1;
        next_cycle();
        meas_valid = 1'b0;
        for (int k = 0; k < U-1; k++)
            for (int c = 0; c < X*Z; c++)
                defects[k*X*Z + c] = defects[(k+1)*X*Z + c];
        for (int c = 0; c < X*Z; c++) defects[(U-1)*X*Z + c] = m[c];
        for (int e = 0; e < EDGES; e++) weights[e] = 0;
    endtask

    task automatic wait_settled();
        int waited;
        waited = 0;
        while (busy != '0) begin
            if (waited >= SETTLE_LIMIT) fail_run("merging did not settle within the cycle limit");
            next_cycle();
            waited++;
        end
        // busy has to stay low one more cycle before the next step.
        next_cycle();
    endtask

    task automatic grow_once();
        grow_step = 1'b1;
        next_cycle();
        grow_step = 1'b0;
        apply_growth();
        next_cycle();
        // a strobe during merging must leave the weights alone.
        if (busy != '0) begin
            grow_step = 1'b1;
            next_cycle();
            grow_step = 1'b0;
            ignored_strobes++;
        end
        wait_settled();
        update_model();
        check_state();
    endtask

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        fail_run($sformatf("run timed out after %0d cycles", TIMEOUT_CYCLES));
    end

    initial begin : stimulus
        logic [31:0] rnd;
        int steps;
        void'($urandom(57));
        rst_n = 1'b0;
        measurements = '0;
        meas_valid = 1'b0;
        grow_step = 1'b0;
        error_count = 0;
        ignored_strobes = 0;
        defects = '0;
        build_edges();
        for (int e = 0; e < EDGES; e++) weights[e] = 0;
        update_model();

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        next_cycle();
        check_state();

        for (int ep = 0; ep < EPISODES; ep++) begin
            for (int r = 0; r < U; r++) begin
                rnd = $urandom();
                load_round(rnd[X*Z-1:0]);
            end
            update_model();
            // no growth yet, so odd is the raw defect of each layer.
            check_value("odd_clusters after loading", odd_clusters, defects);
            check_state();
            steps = 0;
            while (model_odd != '0 && steps < MAX_STEPS) begin
                grow_once();
                steps++;
            end
        end

        if (ignored_strobes == 0) begin
            $display("no grow_step was ever issued while a merge was running");
            error_count++;
        end
        if (error_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "regression ended with errors");
        end
    end

endmodule

// File: vlog.f
+incdir+source
source/decoder_pkg.sv
source/processing_unit.sv
source/edge_link.sv
source/cluster_parity.sv
source/decoding_graph.sv
bench/tb_decoding_graph.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_decoding_graph
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FILE_LIST ?= vlog.f
VFLAGS ?= --binary --timing -Wno-fatal

SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv source/*.svh bench/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM)
	@$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Regression passed" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
